//--- src.f
rtl/core_pkg.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/alu_unit.sv
rtl/write_back.sv
rtl/rv_int_core.sv
sim/tb_rv_int_core.sv

//--- sim/tb_rv_int_core.sv
// Top-level random testbench for the integer core; checks retires and traces against a model
`timescale 1ns/10ps

module tb_rv_int_core;
    import core_pkg::*;

    localparam int NUM_INSTR   = 600;
    localparam int DRAIN       = 4;
    localparam int CYCLE_LIMIT = NUM_INSTR * 2 + 50;
    localparam int NUM_TESTS   = 6;
    localparam int T_RESET     = 0;
    localparam int T_RETIRE    = 1;
    localparam int T_TIMING    = 2;
    localparam int T_X0        = 3;
    localparam int T_TRACE     = 4;
    localparam int T_FINAL     = 5;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [XLEN-1:0]       instr;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_value;
    logic [XLEN-1:0]       retire_count;
    logic                  trace_alu_op;
    logic                  trace_imm_op;
    logic                  trace_illegal;
    logic                  trace_forward;

    // Model state
    integer                seed;
    int                    cycles;
    int                    legal_count;
    logic                  seen_accept;
    logic [XLEN-1:0]       regs [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_val_q [$];
    logic                  exp_x0_q [$];
    logic                  prev_wr;
    logic [REG_ADDR_W-1:0] prev_rd;
    // Bit 0 is what the current cycle must show
    logic [2:0]            due_retire;
    logic [1:0]            due_alu;
    logic [1:0]            due_imm;
    logic [1:0]            due_ill;
    logic [1:0]            due_fwd;
    string                 test_name [NUM_TESTS];
    int                    checks [NUM_TESTS];
    int                    errors [NUM_TESTS];

    rv_int_core i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value),
        .retire_count  (retire_count),
        .trace_alu_op  (trace_alu_op),
        .trace_imm_op  (trace_imm_op),
        .trace_illegal (trace_illegal),
        .trace_forward (trace_forward)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input int t, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        checks[t]++;
        assert (act === exp) else begin
            $display("error: %s expected %h actual %h", test_name[t], exp, act);
            errors[t]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %-7s %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
    endtask

    //////////////////////////////////////////////////
    // ISA reference for the ALU groups
    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 1 : 0;
            F3_SLTU:    return (a < b) ? 1 : 0;
            F3_XOR:     return a ^ b;
            // Sign fill by shifting the inverted word
            F3_SRL_SRA: return (alt && a[XLEN-1]) ? ~(~a >> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // Called just after an edge, once the registered outputs have settled
    task automatic check_outputs();
        int t;
        if (!seen_accept) begin
            check_value(T_RESET, 0, retire_valid);
            check_value(T_RESET, 0, retire_count);
            check_value(T_RESET, 0, {trace_alu_op, trace_imm_op, trace_illegal, trace_forward});
        end
        check_value(T_TIMING, due_retire[0], retire_valid);
        check_value(T_TIMING, due_ill[0], trace_illegal);
        check_value(T_TRACE, {due_alu[0], due_imm[0], due_fwd[0]},
                    {trace_alu_op, trace_imm_op, trace_forward});
        if (retire_valid) begin
            assert (exp_rd_q.size() != 0) else begin
                $display("retire of rd %0d arrived with no instruction outstanding", retire_rd);
                errors[T_RETIRE]++;
            end
            if (exp_rd_q.size() != 0) begin
                t = exp_x0_q.pop_front() ? T_X0 : T_RETIRE;
                check_value(t, exp_rd_q.pop_front(), retire_rd);
                check_value(t, exp_val_q.pop_front(), retire_value);
            end
        end
        due_retire = due_retire >> 1;
        due_alu    = due_alu >> 1;
        due_imm    = due_imm >> 1;
        due_ill    = due_ill >> 1;
        due_fwd    = due_fwd >> 1;
    endtask

    // Draws one cycle of stimulus, updates the model and drives the DUT
    task automatic issue_cycle();
        instr_word_t     w;
        logic            valid;
        logic            legal;
        logic            is_op;
        logic            is_lui;
        logic            alt;
        logic            fwd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        int              kind;

        valid   = ($random(seed) & 3) != 0;
        w       = $random(seed);
        w.r.rs1 = REG_ADDR_W'($unsigned($random(seed)) % 8);
        w.r.rs2 = REG_ADDR_W'($unsigned($random(seed)) % 8);
        w.r.rd  = REG_ADDR_W'($unsigned($random(seed)) % 8);
        kind    = $unsigned($random(seed)) % 3;
        legal   = 1'b1;
        if (kind == 0) begin
            w.r.opcode = OPC_OP;
            w.r.funct7 = F7_BASE;
            if ((w.r.funct3 == F3_ADD_SUB || w.r.funct3 == F3_SRL_SRA) && ($random(seed) & 1))
                w.r.funct7 = F7_ALT;
        end else if (kind == 1) begin
            w.i.opcode = OPC_OP_IMM;
            if (w.i.funct3 == F3_SLL)
                w.r.funct7 = F7_BASE;
            else if (w.i.funct3 == F3_SRL_SRA)
                w.r.funct7 = ($random(seed) & 1) ? F7_ALT : F7_BASE;
        end else begin
            w.u.opcode = OPC_LUI;
        end
        // Roughly one word in sixteen is broken
        if ($unsigned($random(seed)) % 16 == 0) begin
            legal = 1'b0;
            if ($random(seed) & 1) begin
                w.r.opcode = 7'b1111111;
            end else begin
                w.r.opcode = OPC_OP;
                w.r.funct7 = 7'b0000001;
            end
        end
        is_op  = (w.r.opcode == OPC_OP);
        is_lui = (w.r.opcode == OPC_LUI);

        if (valid && !seen_accept) begin
            seen_accept = 1'b1;
            report_test(T_RESET);
        end
        if (valid && !legal)
            due_ill[1] = 1'b1;
        if (valid && legal) begin
            legal_count++;
            a   = is_lui ? '0 : regs[w.r.rs1];
            b   = is_op ? regs[w.r.rs2] : {{(XLEN-12){w.i.imm[11]}}, w.i.imm};
            alt = (w.r.funct7 == F7_ALT) && (is_op || w.r.funct3 == F3_SRL_SRA);
            res = is_lui ? {w.u.imm, 12'b0} : alu_model(w.r.funct3, alt, a, b);
            fwd = prev_wr && ((!is_lui && prev_rd == w.r.rs1) || (is_op && prev_rd == w.r.rs2));
            due_retire[2] = 1'b1;
            due_alu[1]    = is_op;
            due_imm[1]    = !is_op;
            due_fwd[1]    = fwd;
            exp_rd_q.push_back(w.r.rd);
            exp_val_q.push_back(res);
            exp_x0_q.push_back(w.r.rd == 0 || (!is_lui && w.r.rs1 == 0) ||
                               (is_op && w.r.rs2 == 0));
            if (w.r.rd != 0)
                regs[w.r.rd] = res;
        end
        prev_wr     = valid && legal && (w.r.rd != 0);
        prev_rd     = w.r.rd;
        instr_valid = valid;
        instr       = w;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        int total_checks;
        int total_errors;

        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 68;
        cycles      = 0;
        legal_count = 0;
        seen_accept = 1'b0;
        prev_wr     = 1'b0;
        prev_rd     = '0;
        due_retire  = '0;
        due_alu     = '0;
        due_imm     = '0;
        due_ill     = '0;
        due_fwd     = '0;
        test_name   = '{"reset", "retire", "timing", "x0", "trace", "final"};
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end

        repeat (5) begin
            @(posedge clk);
            #1;
            check_outputs();
        end
        rst_n = 1'b1;

        for (int n = 0; n < NUM_INSTR; n++) begin
            issue_cycle();
            @(posedge clk);
            #1;
            check_outputs();
        end
        instr_valid = 1'b0;
        repeat (DRAIN) begin
            @(posedge clk);
            #1;
            check_outputs();
        end

        check_value(T_FINAL, legal_count, retire_count);
        checks[T_FINAL]++;
        assert (exp_rd_q.size() == 0) else begin
            $display("%0d expected retires never appeared", exp_rd_q.size());
            errors[T_FINAL]++;
        end

        if (!seen_accept)
            report_test(T_RESET);
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (t != T_RESET)
                report_test(t);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("instructions %0d, retired %0d, checks %0d, errors %0d",
                 NUM_INSTR, legal_count, total_checks, total_errors);
        if (total_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- rtl/rv_int_core.sv
// Top level of the integer core slice; connects decode, register file, execute and writeback
`timescale 1ns/10ps

module rv_int_core (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_valid,
    input  logic [core_pkg::XLEN-1:0]        instr,
    output logic                             retire_valid,
    output logic [core_pkg::REG_ADDR_W-1:0]  retire_rd,
    output logic [core_pkg::XLEN-1:0]        retire_value,
    output logic [core_pkg::XLEN-1:0]        retire_count,
    output logic                             trace_alu_op,
    output logic                             trace_imm_op,
    output logic                             trace_illegal,
    output logic                             trace_forward
);
    import core_pkg::*;

    // Decode to execute
    logic                  dec_valid;
    logic [ALU_OP_W-1:0]   dec_op;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [XLEN-1:0]       dec_imm;
    logic                  dec_use_imm;
    logic                  dec_wr;

    // Register file ports
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_wr_en;
    logic [REG_ADDR_W-1:0] rf_wr_addr;
    logic [XLEN-1:0]       rf_wr_data;

    // Execute to writeback
    logic                  ex_valid;
    logic                  ex_wr;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_result;

    // Trace events
    logic tr_alu_op;
    logic tr_imm_op;
    logic tr_illegal;
    logic tr_forward;

    //////////////////////////////////////////////////
    // Stages
    instr_decode decode_block (.*);

    register_file register_file_block (
        .*,
        .wr_en   (rf_wr_en),
        .wr_addr (rf_wr_addr),
        .wr_data (rf_wr_data)
    );

    alu_unit alu_unit_block (.*);

    write_back write_back_block (.*);

    //////////////////////////////////////////////////
    // Trace outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_alu_op  <= 1'b0;
            trace_imm_op  <= 1'b0;
            trace_illegal <= 1'b0;
            trace_forward <= 1'b0;
        end else begin
            trace_alu_op  <= tr_alu_op;
            trace_imm_op  <= tr_imm_op;
            trace_illegal <= tr_illegal;
            trace_forward <= tr_forward;
        end
    end

endmodule

//--- rtl/write_back.sv
// Writeback stage; drives the register file write and registers the retire port and count
`timescale 1ns/10ps

module write_back (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ex_valid,
    input  logic                             ex_wr,
    input  logic [core_pkg::REG_ADDR_W-1:0]  ex_rd,
    input  logic [core_pkg::XLEN-1:0]        ex_result,
    output logic                             rf_wr_en,
    output logic [core_pkg::REG_ADDR_W-1:0]  rf_wr_addr,
    output logic [core_pkg::XLEN-1:0]        rf_wr_data,
    output logic                             retire_valid,
    output logic [core_pkg::REG_ADDR_W-1:0]  retire_rd,
    output logic [core_pkg::XLEN-1:0]        retire_value,
    output logic [core_pkg::XLEN-1:0]        retire_count
);
    import core_pkg::*;

    // Write lands at the same edge the retire port is registered
    assign rf_wr_en   = ex_valid && ex_wr;
    assign rf_wr_addr = ex_rd;
    assign rf_wr_data = ex_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_count <= '0;
        end else begin
            retire_valid <= ex_valid;
            if (ex_valid)
                retire_count <= retire_count + XLEN'(1);
        end
    end

    // x0 destinations retire too
    always_ff @(posedge clk) begin
        retire_rd    <= ex_rd;
        retire_value <= ex_result;
    end

endmodule

//--- rtl/alu_unit.sv
// Execute stage; reads operands with forwarding from its result register and computes the ALU op
`timescale 1ns/10ps

module alu_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             dec_valid,
    input  logic [core_pkg::ALU_OP_W-1:0]    dec_op,
    input  logic [core_pkg::REG_ADDR_W-1:0]  dec_rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0]  dec_rs2,
    input  logic [core_pkg::REG_ADDR_W-1:0]  dec_rd,
    input  logic [core_pkg::XLEN-1:0]        dec_imm,
    input  logic                             dec_use_imm,
    input  logic                             dec_wr,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  logic [core_pkg::XLEN-1:0]        rs1_data,
    input  logic [core_pkg::XLEN-1:0]        rs2_data,
    output logic                             ex_valid,
    output logic                             ex_wr,
    output logic [core_pkg::REG_ADDR_W-1:0]  ex_rd,
    output logic [core_pkg::XLEN-1:0]        ex_result,
    output logic                             tr_forward
);
    import core_pkg::*;

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    //////////////////////////////////////////////////
    // Operand selection
    // ex_wr already excludes rd == x0
    assign fwd_rs1 = ex_valid && ex_wr && (ex_rd == dec_rs1);
    assign fwd_rs2 = ex_valid && ex_wr && !dec_use_imm && (ex_rd == dec_rs2);

    assign op_a    = fwd_rs1 ? ex_result : rs1_data;
    assign rs2_val = fwd_rs2 ? ex_result : rs2_data;
    assign op_b    = dec_use_imm ? dec_imm : rs2_val;
    assign shamt   = op_b[4:0];

    assign tr_forward = dec_valid && (fwd_rs1 || fwd_rs2);

    //////////////////////////////////////////////////
    // ALU
    always_comb begin
        case (dec_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
            ex_wr    <= dec_valid && dec_wr;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd     <= dec_rd;
        ex_result <= result;
    end

endmodule

//--- rtl/register_file.sv
// Architectural register file; two asynchronous read ports and one write port, x0 reads zero
`timescale 1ns/10ps

module register_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr,
    output logic [core_pkg::XLEN-1:0]        rs1_data,
    output logic [core_pkg::XLEN-1:0]        rs2_data,
    input  logic                             wr_en,
    input  logic [core_pkg::REG_ADDR_W-1:0]  wr_addr,
    input  logic [core_pkg::XLEN-1:0]        wr_data
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Entry zero masked on read, so a write to x0 is harmless
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- rtl/instr_decode.sv
// Decode stage; classifies each strobed instruction word and registers the fields for execute
`timescale 1ns/10ps

module instr_decode (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_valid,
    input  core_pkg::instr_word_t            instr,
    output logic                             dec_valid,
    output logic [core_pkg::ALU_OP_W-1:0]    dec_op,
    output logic [core_pkg::REG_ADDR_W-1:0]  dec_rs1,
    output logic [core_pkg::REG_ADDR_W-1:0]  dec_rs2,
    output logic [core_pkg::REG_ADDR_W-1:0]  dec_rd,
    output logic [core_pkg::XLEN-1:0]        dec_imm,
    output logic                             dec_use_imm,
    output logic                             dec_wr,
    output logic                             tr_alu_op,
    output logic                             tr_imm_op,
    output logic                             tr_illegal
);
    import core_pkg::*;

    logic                is_op;
    logic                is_op_imm;
    logic                is_lui;
    logic                f7_base;
    logic                f7_alt;
    logic                use_alt;
    logic                legal;
    logic                accept;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     imm;

    assign is_op     = (instr.r.opcode == OPC_OP);
    assign is_op_imm = (instr.r.opcode == OPC_OP_IMM);
    assign is_lui    = (instr.r.opcode == OPC_LUI);
    assign f7_base   = (instr.r.funct7 == F7_BASE);
    assign f7_alt    = (instr.r.funct7 == F7_ALT);

    // For OP-IMM the funct7 slot is immediate, except on shifts
    assign use_alt = f7_alt && (is_op || instr.r.funct3 == F3_SRL_SRA);

    always_comb begin
        legal = 1'b0;
        if (is_lui)
            legal = 1'b1;
        else if (is_op)
            legal = f7_base || (f7_alt && (instr.r.funct3 == F3_ADD_SUB ||
                                           instr.r.funct3 == F3_SRL_SRA));
        else if (is_op_imm) begin
            case (instr.i.funct3)
                F3_SLL:     legal = f7_base;
                F3_SRL_SRA: legal = f7_base || f7_alt;
                default:    legal = 1'b1;
            endcase
        end
    end

    always_comb begin
        case (instr.r.funct3)
            F3_ADD_SUB: alu_op = use_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = use_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
        // LUI is x0 + upper immediate
        if (is_lui)
            alu_op = ALU_ADD;
    end

    assign imm = is_lui ? {instr.u.imm, 12'b0} : {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    assign accept = instr_valid && legal;

    // Control and trace class pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid  <= 1'b0;
            dec_wr     <= 1'b0;
            tr_alu_op  <= 1'b0;
            tr_imm_op  <= 1'b0;
            tr_illegal <= 1'b0;
        end else begin
            dec_valid  <= accept;
            dec_wr     <= accept && (instr.r.rd != '0);
            tr_alu_op  <= accept && is_op;
            tr_imm_op  <= accept && (is_op_imm || is_lui);
            tr_illegal <= instr_valid && !legal;
        end
    end

    // Decoded fields qualified by dec_valid
    always_ff @(posedge clk) begin
        dec_op      <= alu_op;
        dec_rs1     <= is_lui ? '0 : instr.r.rs1;
        dec_rs2     <= instr.r.rs2;
        dec_rd      <= instr.r.rd;
        dec_imm     <= imm;
        dec_use_imm <= !is_op;
    end

endmodule

//--- rtl/core_pkg.sv
// Shared widths, RISC-V encodings and instruction word views; imported by every core module
package core_pkg;

    //////////////////////////////////////////////////
    // Widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Accepted major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate funct7 selects sub and arithmetic shift right
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    //////////////////////////////////////////////////
    // ALU operation codes
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    //////////////////////////////////////////////////
    // Instruction word views
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instr_word_t;

endpackage
